/* top_pipeline.f */
verilog/debug_pkg.sv
verilog/baud_rate_gen.sv
verilog/uart_receiver.sv
verilog/uart_transmitter.sv
verilog/fifo_transmitter.sv
verilog/debug_unit.sv
verilog/pipeline.sv
verilog/top_pipeline.sv
verification/tb_clock_gen.sv
verification/top_pipeline_chk.sv
verification/tb_top_pipeline.sv

/* verification/tb_clock_gen.sv */
`timescale 1ns/100ps

module tb_clock_gen (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #2 o_clk = ~o_clk;                                  // 4 ns period

endmodule

/* verification/tb_top_pipeline.sv */
`timescale 1ns/100ps

module tb_top_pipeline;

    logic                            clk;
    logic                            reset;
    logic                            rx_line;                  // Host to DUT
    logic                            tx_line;                  // DUT to host
    logic [debug_pkg::WORD_BITS-1:0] replies [$];              // Decoded reply frames
    debug_pkg::instr_u               prog [$];                 // Program as sent
    logic [debug_pkg::WORD_BITS-1:0] model_regs [debug_pkg::REG_COUNT];
    int                              checks = 0;
    int                              errors = 0;

    tb_clock_gen u_clock_gen (
        .o_clk (clk)
    );

    top_pipeline i_dut (
        .i_clk   (clk),
        .i_reset (reset),
        .i_rx    (rx_line),
        .o_tx    (tx_line)
    );

    bind top_pipeline top_pipeline_chk u_chk (
        .i_clk          (i_clk),
        .i_reset        (i_reset),
        .i_fifo_push    (fifo_push),
        .i_tx_valid     (tx_valid),
        .i_tx_done      (tx_done),
        .i_tx           (o_tx),
        .i_credit_cnt   (u_debug_unit.credit_cnt),
        .i_fifo_count   (u_fifo_transmitter.count),
        .i_exec_advance (u_pipeline.advance),
        .i_exec_valid   (u_pipeline.if_id_valid),
        .i_exec_opcode  (u_pipeline.if_id_instr.r.opcode),
        .i_program_end  (program_end),
        .i_core_reset   (core_reset)
    );

    function automatic int bit_clocks();
        return debug_pkg::STOP_TICKS * debug_pkg::BAUD_DIVISOR;   // 64 clocks
    endfunction

    function automatic int frame_clocks();
        return (debug_pkg::WORD_BITS + 2) * bit_clocks();         // Start, 32 data, stop
    endfunction

    function automatic debug_pkg::instr_u make_addi(int rd, int rs, logic [15:0] imm);
        debug_pkg::instr_u ins;
        ins          = '0;
        ins.i.opcode = debug_pkg::OP_ADDI;
        ins.i.rd     = rd[debug_pkg::REG_ADDR_BITS-1:0];
        ins.i.rs     = rs[debug_pkg::REG_ADDR_BITS-1:0];
        ins.i.imm    = imm;
        return ins;
    endfunction

    function automatic debug_pkg::instr_u make_add(int rd, int rs, int rt);
        debug_pkg::instr_u ins;
        ins          = '0;
        ins.r.opcode = debug_pkg::OP_ADD;
        ins.r.rd     = rd[debug_pkg::REG_ADDR_BITS-1:0];
        ins.r.rs     = rs[debug_pkg::REG_ADDR_BITS-1:0];
        ins.r.rt     = rt[debug_pkg::REG_ADDR_BITS-1:0];
        return ins;
    endfunction

    // Reference model, returns 1 on HALT
    function automatic bit model_exec(debug_pkg::instr_u ins);
        case (ins.r.opcode)
            debug_pkg::OP_ADD: if (ins.r.rd != 0) begin
                model_regs[ins.r.rd] = model_regs[ins.r.rs] + model_regs[ins.r.rt];
            end
            debug_pkg::OP_ADDI: if (ins.i.rd != 0) begin
                model_regs[ins.i.rd] = model_regs[ins.i.rs] + 32'($signed(ins.i.imm));
            end
            debug_pkg::OP_HALT: return 1'b1;
            default: ;
        endcase
        return 1'b0;
    endfunction

    function automatic void model_reset();
        for (int k = 0; k < debug_pkg::REG_COUNT; k++) model_regs[k] = '0;
    endfunction

    function automatic void build_program(int n);
        prog.delete();
        prog.push_back(make_addi($urandom_range(1, 7), 0, 16'($urandom)));  // Seed a value
        for (int k = 1; k < n - 1; k++) begin
            if ($urandom_range(0, 1) == 1) begin
                prog.push_back(make_add($urandom_range(0, 7), $urandom_range(0, 7),
                                        $urandom_range(0, 7)));
            end else begin
                prog.push_back(make_addi($urandom_range(0, 7), $urandom_range(0, 7),
                                         16'($urandom)));
            end
        end
        prog.push_back(debug_pkg::instr_u'({debug_pkg::OP_HALT, 26'd0}));
    endfunction

    // Host side of the serial line, LSB first
    task automatic send_word(input logic [debug_pkg::WORD_BITS-1:0] word);
        rx_line = 1'b0;                                        // Start bit
        repeat (bit_clocks()) @(negedge clk);
        for (int b = 0; b < debug_pkg::WORD_BITS; b++) begin
            rx_line = word[b];
            repeat (bit_clocks()) @(negedge clk);
        end
        rx_line = 1'b1;                                        // Stop bit and short gap
        repeat (bit_clocks() + 8) @(negedge clk);
    endtask

    task automatic send_cmd(input debug_pkg::debug_cmd_e cmd, input int arg);
        debug_pkg::debug_cmd_t frame;
        frame.cmd = cmd;
        frame.arg = arg[23:0];
        send_word(frame);
    endtask

    task automatic load_program();
        for (int a = 0; a < prog.size(); a++) begin
            send_cmd(debug_pkg::CMD_LOAD, a);
            send_word(prog[a]);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic get_reply(output logic [31:0] word, output bit got);
        int waited;
        waited = 0;
        while (replies.size() == 0 && waited < 2 * frame_clocks()) begin
            @(negedge clk);
            waited++;
        end
        got = (replies.size() != 0);
        if (got) begin
            word = replies.pop_front();
        end else begin
            word = 'x;
            errors++;
            $display("no reply frame arrived within %0d clocks", waited);
        end
    endtask

    task automatic check_reply(input logic [31:0] exp, input string what);
        logic [31:0] word;
        bit          got;
        get_reply(word, got);
        if (got) check_word(word, exp, what);
    endtask

    // Frame monitor on o_tx, samples near mid-bit
    initial begin
        logic [debug_pkg::WORD_BITS-1:0] word;
        forever begin
            @(negedge clk);
            if (tx_line === 1'b0) begin
                repeat (bit_clocks() / 2) @(negedge clk);      // Middle of start bit
                for (int b = 0; b < debug_pkg::WORD_BITS; b++) begin
                    repeat (bit_clocks()) @(negedge clk);
                    word[b] = tx_line;
                end
                repeat (bit_clocks()) @(negedge clk);
                checks++;
                assert (tx_line === 1'b1) else begin
                    errors++;
                    $display("reply frame at %0t has a low stop bit", $time);
                end
                replies.push_back(word);                       // Stop bit ends the reply
            end
        end
    end

    initial begin
        repeat (40 * frame_clocks()) @(posedge clk);           // 87040 clocks
        $display("watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        logic [31:0] word;
        bit          got;
        int          ra;
        int          rb;
        void'($urandom(70));
        reset   = 1'b1;
        rx_line = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        // Quiet line after reset
        repeat (4 * bit_clocks()) begin
            @(negedge clk);
            check_word({31'b0, tx_line}, 32'd1, "idle line after reset");
        end
        check_word(replies.size(), 0, "frames after reset");

        // Random program, run, two register reads
        build_program(5);
        model_reset();
        foreach (prog[k]) if (model_exec(prog[k])) break;
        load_program();
        send_cmd(debug_pkg::CMD_RUN, 0);
        ra = $urandom_range(1, 7);
        rb = $urandom_range(1, 7);
        send_cmd(debug_pkg::CMD_READ_REG, ra);
        check_reply(model_regs[ra], "register read after run");
        send_cmd(debug_pkg::CMD_READ_REG, rb);
        check_reply(model_regs[rb], "second register read after run");
        check_word({31'b0, i_dut.program_end}, 32'd1, "program end after run");

        // Dump outruns the four credits
        send_cmd(debug_pkg::CMD_DUMP, 0);
        for (int r = 0; r < debug_pkg::REG_COUNT; r++) begin
            get_reply(word, got);
            if (got) check_word(word, model_regs[r], $sformatf("dump register %0d", r));
            if (got && r == 0) check_word(word, '0, "dump register 0 is zero");
        end

        // Core reset, reload, single step
        send_cmd(debug_pkg::CMD_RESET, 0);
        model_reset();
        ra      = $urandom_range(1, 7);
        prog[0] = make_addi(ra, $urandom_range(0, 7), 16'($urandom));
        send_cmd(debug_pkg::CMD_LOAD, 0);
        send_word(prog[0]);
        send_cmd(debug_pkg::CMD_STEP, 0);
        void'(model_exec(prog[0]));
        send_cmd(debug_pkg::CMD_READ_REG, ra);
        check_reply(model_regs[ra], "register read after one step");
        check_word({31'b0, i_dut.program_end}, 32'd0, "program end after one step");
        check_word(replies.size(), 0, "extra reply frames");

        repeat (8) @(negedge clk);
        $display("checks %0d, testbench errors %0d, assertion failures %0d",
                 checks, errors, i_dut.u_chk.fail_count);
        if (errors == 0 && i_dut.u_chk.fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* verification/top_pipeline_chk.sv */
`timescale 1ns/100ps

module top_pipeline_chk (
    input logic                              i_clk,
    input logic                              i_reset,
    input logic                              i_fifo_push,      // Debug unit push
    input logic                              i_tx_valid,       // FIFO not empty
    input logic                              i_tx_done,        // Transmitter took a word
    input logic                              i_tx,             // Serial out
    input logic [debug_pkg::CREDIT_BITS-1:0] i_credit_cnt,
    input logic [debug_pkg::CREDIT_BITS-1:0] i_fifo_count,
    input logic                              i_exec_advance,   // Core stages enabled
    input logic                              i_exec_valid,     // IF/ID latch holds an instr
    input debug_pkg::opcode_e                i_exec_opcode,
    input logic                              i_program_end,
    input logic                              i_core_reset
);

    int          fail_count = 0;                               // Failed assertions so far
    logic [15:0] frame_left;                                   // Clocks left in the frame
    logic        halt_exec;

    assign halt_exec = i_exec_advance && i_exec_valid && (i_exec_opcode == debug_pkg::OP_HALT);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            frame_left <= '0;
        end else if (i_tx_done) begin
            frame_left <= 16'((debug_pkg::WORD_BITS + 2) * debug_pkg::STOP_TICKS *
                              debug_pkg::BAUD_DIVISOR);        // Start, data, stop
        end else if (frame_left != '0) begin
            frame_left <= frame_left - 1'b1;
        end
    end

    line_idle: assert property (@(posedge i_clk) disable iff (i_reset)
        !i_tx_valid && (frame_left == '0) |-> i_tx)
        else begin fail_count++; $error("serial line active with empty FIFO"); end

    // A push spends a credit and so needs a free slot
    no_overflow: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fifo_push |-> (i_fifo_count < debug_pkg::FIFO_DEPTH))
        else begin fail_count++; $error("push into a full FIFO"); end

    // Every slot is either a credit or a stored word
    credit_balance: assert property (@(posedge i_clk) disable iff (i_reset)
        (i_credit_cnt + i_fifo_count) == debug_pkg::FIFO_DEPTH)
        else begin fail_count++; $error("credits and FIFO count out of balance"); end

    end_after_halt: assert property (@(posedge i_clk) disable iff (i_reset)
        $rose(i_program_end) |-> $past(halt_exec))
        else begin fail_count++; $error("program end without an executed HALT"); end

    end_sticky: assert property (@(posedge i_clk) disable iff (i_reset)
        i_program_end && !i_core_reset |=> i_program_end)
        else begin fail_count++; $error("program end dropped without core reset"); end

endmodule

/* verilog/baud_rate_gen.sv */
`timescale 1ns/100ps

module baud_rate_gen (
    input  logic i_clk,
    input  logic i_reset,
    output logic o_baud_tick                                   // One clock every BAUD_DIVISOR
);

    logic [debug_pkg::DIV_BITS-1:0] div_cnt;                   // Clocks since last tick

    assign o_baud_tick = (div_cnt == debug_pkg::BAUD_DIVISOR - 1);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            div_cnt <= '0;
        end else if (o_baud_tick) begin
            div_cnt <= '0;                                     // Restart the period
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

endmodule

/* verilog/debug_pkg.sv */
package debug_pkg;

    localparam int WORD_BITS      = 32;                        // UART frame and register width
    localparam int STOP_TICKS     = 16;                        // Baud ticks per bit
    localparam int BAUD_DIVISOR   = 4;                         // Clocks per baud tick
    localparam int FIFO_DEPTH     = 4;                         // Tx FIFO entries, also start credits
    localparam int REG_COUNT      = 8;
    localparam int REG_ADDR_BITS  = 3;
    localparam int INST_DEPTH     = 16;
    localparam int INST_ADDR_BITS = 4;
    localparam int TICK_BITS      = $clog2(STOP_TICKS);        // Wraps once per bit
    localparam int BIT_CNT_BITS   = $clog2(WORD_BITS);
    localparam int DIV_BITS       = $clog2(BAUD_DIVISOR);
    localparam int FIFO_ADDR_BITS = $clog2(FIFO_DEPTH);
    localparam int CREDIT_BITS    = $clog2(FIFO_DEPTH + 1);    // Holds 0 to FIFO_DEPTH
    localparam logic [CREDIT_BITS-1:0] CREDIT_INIT = FIFO_DEPTH[CREDIT_BITS-1:0];

    typedef enum logic [7:0] {
        CMD_LOAD     = 8'h01,                                  // arg = address, next word = instr
        CMD_RUN      = 8'h02,
        CMD_STEP     = 8'h03,
        CMD_READ_REG = 8'h04,                                  // arg = register number
        CMD_DUMP     = 8'h05,
        CMD_RESET    = 8'h06
    } debug_cmd_e;

    typedef struct packed {
        debug_cmd_e  cmd;
        logic [23:0] arg;
    } debug_cmd_t;

    typedef enum logic [5:0] {
        OP_ADD  = 6'h01,
        OP_ADDI = 6'h08,
        OP_HALT = 6'h3f
    } opcode_e;

    typedef struct packed {
        opcode_e                  opcode;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs;
        logic [REG_ADDR_BITS-1:0] rt;
        logic [16:0]              spare;                       // Unused in R-type
    } r_type_t;

    typedef struct packed {
        opcode_e                  opcode;
        logic [REG_ADDR_BITS-1:0] rd;
        logic [REG_ADDR_BITS-1:0] rs;
        logic [3:0]               spare;
        logic [15:0]              imm;                         // Signed immediate
    } i_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
    } instr_u;

endpackage

/* verilog/debug_unit.sv */
`timescale 1ns/100ps

module debug_unit (
    input  logic                                 i_clk,
    input  logic                                 i_reset,
    input  logic                                 i_rx_done,
    input  logic [debug_pkg::WORD_BITS-1:0]      i_rx_data,
    input  logic                                 i_credit_return,
    input  logic [debug_pkg::WORD_BITS-1:0]      i_reg_data,
    input  logic                                 i_program_end,
    output logic                                 o_fifo_push,
    output logic [debug_pkg::WORD_BITS-1:0]      o_fifo_data,
    output logic                                 o_load_we,
    output logic [debug_pkg::INST_ADDR_BITS-1:0] o_load_addr,
    output logic [debug_pkg::WORD_BITS-1:0]      o_load_instr,
    output logic                                 o_advance,    // Clock enable for the core
    output logic                                 o_core_reset,
    output logic [debug_pkg::REG_ADDR_BITS-1:0]  o_reg_addr
);

    typedef enum logic [1:0] {DBG_IDLE, DBG_LOAD_WAIT, DBG_RUN, DBG_DUMP} dbg_state_e;

    dbg_state_e                          state;
    debug_pkg::debug_cmd_t               cmd;
    logic [debug_pkg::CREDIT_BITS-1:0]   credit_cnt;           // Free FIFO slots
    logic [debug_pkg::REG_ADDR_BITS-1:0] last_addr;            // Final register of a dump
    logic                                step_q;               // Single advance pulse
    logic                                new_cmd;

    assign cmd         = debug_pkg::debug_cmd_t'(i_rx_data);
    assign new_cmd     = (state == DBG_IDLE) && i_rx_done;
    assign o_fifo_push = (state == DBG_DUMP) && (credit_cnt != '0);  // Stall at zero credit
    assign o_fifo_data = i_reg_data;
    assign o_advance   = ((state == DBG_RUN) && !i_program_end) || step_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state        <= DBG_IDLE;
            credit_cnt   <= debug_pkg::CREDIT_INIT;
            step_q       <= 1'b0;
            o_load_we    <= 1'b0;
            o_core_reset <= 1'b0;
        end else begin
            step_q       <= 1'b0;
            o_load_we    <= 1'b0;
            o_core_reset <= 1'b0;
            case ({o_fifo_push, i_credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;      // Push spends one
                2'b01:   credit_cnt <= credit_cnt + 1'b1;      // Word left the FIFO
                default: credit_cnt <= credit_cnt;
            endcase
            case (state)
                DBG_IDLE: if (i_rx_done) begin
                    case (cmd.cmd)
                        debug_pkg::CMD_LOAD:     state        <= DBG_LOAD_WAIT;
                        debug_pkg::CMD_RUN:      state        <= DBG_RUN;
                        debug_pkg::CMD_STEP:     step_q       <= 1'b1;
                        debug_pkg::CMD_READ_REG: state        <= DBG_DUMP;
                        debug_pkg::CMD_DUMP:     state        <= DBG_DUMP;
                        debug_pkg::CMD_RESET:    o_core_reset <= 1'b1;
                        default:                 state        <= DBG_IDLE;  // Ignore junk
                    endcase
                end
                DBG_LOAD_WAIT: if (i_rx_done) begin
                    o_load_we <= 1'b1;                         // Word is the instruction
                    state     <= DBG_IDLE;
                end
                DBG_RUN: if (i_program_end) state <= DBG_IDLE;
                DBG_DUMP: if (o_fifo_push && o_reg_addr == last_addr) state <= DBG_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (new_cmd && cmd.cmd == debug_pkg::CMD_LOAD) begin
            o_load_addr <= cmd.arg[debug_pkg::INST_ADDR_BITS-1:0];
        end
        if (state == DBG_LOAD_WAIT && i_rx_done) o_load_instr <= i_rx_data;
        if (new_cmd && cmd.cmd == debug_pkg::CMD_READ_REG) begin
            o_reg_addr <= cmd.arg[debug_pkg::REG_ADDR_BITS-1:0];
            last_addr  <= cmd.arg[debug_pkg::REG_ADDR_BITS-1:0];  // Dump of one
        end else if (new_cmd && cmd.cmd == debug_pkg::CMD_DUMP) begin
            o_reg_addr <= '0;
            last_addr  <= '1;                                  // Through the last register
        end else if (o_fifo_push) begin
            o_reg_addr <= o_reg_addr + 1'b1;
        end
    end

endmodule

/* verilog/fifo_transmitter.sv */
`timescale 1ns/100ps

module fifo_transmitter (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_push,
    input  logic [debug_pkg::WORD_BITS-1:0] i_push_data,
    input  logic                            i_pop,             // From tx done
    output logic                            o_tx_valid,        // Not empty
    output logic [debug_pkg::WORD_BITS-1:0] o_pop_data,
    output logic                            o_credit_return    // One credit per word sent
);

    logic [debug_pkg::WORD_BITS-1:0]      mem [debug_pkg::FIFO_DEPTH];
    logic [debug_pkg::FIFO_ADDR_BITS-1:0] wr_ptr;
    logic [debug_pkg::FIFO_ADDR_BITS-1:0] rd_ptr;
    logic [debug_pkg::CREDIT_BITS-1:0]    count;
    logic                                 do_push;
    logic                                 do_pop;

    assign do_push         = i_push && (count != debug_pkg::CREDIT_INIT);
    assign do_pop          = i_pop && o_tx_valid;
    assign o_tx_valid      = (count != '0);
    assign o_pop_data      = mem[rd_ptr];                      // Head of queue
    assign o_credit_return = do_pop;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;              // Pointers wrap at depth
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                       // Both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr] <= i_push_data;
    end

endmodule

/* verilog/pipeline.sv */
`timescale 1ns/100ps

module pipeline (
    input  logic                                 i_clk,
    input  logic                                 i_reset,      // Clears program memory
    input  logic                                 i_core_reset, // Clears PC, latch, registers
    input  logic                                 i_advance,
    input  logic                                 i_load_we,
    input  logic [debug_pkg::INST_ADDR_BITS-1:0] i_load_addr,
    input  logic [debug_pkg::WORD_BITS-1:0]      i_load_instr,
    input  logic [debug_pkg::REG_ADDR_BITS-1:0]  i_reg_addr,
    output logic [debug_pkg::WORD_BITS-1:0]      o_reg_data,
    output logic                                 o_program_end
);

    logic [debug_pkg::WORD_BITS-1:0]      inst_mem [debug_pkg::INST_DEPTH];
    logic [debug_pkg::WORD_BITS-1:0]      regs [debug_pkg::REG_COUNT];
    logic [debug_pkg::INST_ADDR_BITS-1:0] pc;
    debug_pkg::instr_u                    if_id_instr;         // IF/ID latch
    logic                                 if_id_valid;
    logic                                 advance;
    logic                                 fetch_en;
    logic [debug_pkg::WORD_BITS-1:0]      src_a;
    logic [debug_pkg::WORD_BITS-1:0]      imm_ext;

    assign advance    = i_advance && !o_program_end;           // HALT freezes both stages
    assign fetch_en   = advance || !if_id_valid;               // Empty latch fills by itself
    assign src_a      = regs[if_id_instr.r.rs];                // rs shared by both views
    assign imm_ext    = {{16{if_id_instr.i.imm[15]}}, if_id_instr.i.imm};
    assign o_reg_data = regs[i_reg_addr];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            for (int k = 0; k < debug_pkg::INST_DEPTH; k++) inst_mem[k] <= '0;
        end else if (i_load_we) begin
            inst_mem[i_load_addr] <= i_load_instr;
        end
    end

    // Fetch restarts the program from address 0 after a load
    always_ff @(posedge i_clk) begin
        if (i_core_reset || i_load_we) begin
            pc          <= '0;
            if_id_valid <= 1'b0;
        end else if (fetch_en) begin
            if_id_instr <= inst_mem[pc];
            if_id_valid <= 1'b1;
            pc          <= pc + 1'b1;
        end
    end

    // Execute
    always_ff @(posedge i_clk) begin
        if (i_core_reset) begin
            for (int k = 0; k < debug_pkg::REG_COUNT; k++) regs[k] <= '0;
            o_program_end <= 1'b0;
        end else if (advance && if_id_valid) begin
            case (if_id_instr.r.opcode)
                debug_pkg::OP_ADD: if (if_id_instr.r.rd != '0) begin
                    regs[if_id_instr.r.rd] <= src_a + regs[if_id_instr.r.rt];
                end
                debug_pkg::OP_ADDI: if (if_id_instr.i.rd != '0) begin
                    regs[if_id_instr.i.rd] <= src_a + imm_ext;  // r0 stays zero
                end
                debug_pkg::OP_HALT: o_program_end <= 1'b1;      // Sticky until core reset
                default: ;                                      // Other codes act as no-ops
            endcase
        end
    end

endmodule

/* verilog/top_pipeline.sv */
`timescale 1ns/100ps

module top_pipeline (
    input  logic i_clk,
    input  logic i_reset,
    input  logic i_rx,                                         // Serial in from host
    output logic o_tx                                          // Serial out to host
);

    logic                                 baud_tick;
    logic                                 rx_done;
    logic [debug_pkg::WORD_BITS-1:0]      rx_data;
    logic                                 fifo_push;
    logic [debug_pkg::WORD_BITS-1:0]      fifo_data;
    logic                                 credit_return;
    logic                                 tx_valid;
    logic [debug_pkg::WORD_BITS-1:0]      tx_data;
    logic                                 tx_done;
    logic                                 load_we;
    logic [debug_pkg::INST_ADDR_BITS-1:0] load_addr;
    logic [debug_pkg::WORD_BITS-1:0]      load_instr;
    logic                                 advance;
    logic                                 dbg_core_reset;
    logic                                 core_reset;
    logic [debug_pkg::REG_ADDR_BITS-1:0]  reg_addr;
    logic [debug_pkg::WORD_BITS-1:0]      reg_data;
    logic                                 program_end;

    assign core_reset = i_reset | dbg_core_reset;              // Debug can restart the core

    baud_rate_gen u_baud_rate_gen (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .o_baud_tick (baud_tick)
    );

    uart_receiver u_uart_receiver (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_rx        (i_rx),
        .i_baud_tick (baud_tick),
        .o_rx_done   (rx_done),
        .o_data      (rx_data)
    );

    fifo_transmitter u_fifo_transmitter (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_push          (fifo_push),
        .i_push_data     (fifo_data),
        .i_pop           (tx_done),                            // Pop as the word is latched
        .o_tx_valid      (tx_valid),
        .o_pop_data      (tx_data),
        .o_credit_return (credit_return)
    );

    uart_transmitter u_uart_transmitter (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_tx_valid  (tx_valid),
        .i_data      (tx_data),
        .i_baud_tick (baud_tick),
        .o_tx_done   (tx_done),
        .o_tx        (o_tx)
    );

    debug_unit u_debug_unit (
        .i_clk           (i_clk),
        .i_reset         (i_reset),
        .i_rx_done       (rx_done),
        .i_rx_data       (rx_data),
        .i_credit_return (credit_return),
        .i_reg_data      (reg_data),
        .i_program_end   (program_end),
        .o_fifo_push     (fifo_push),
        .o_fifo_data     (fifo_data),
        .o_load_we       (load_we),
        .o_load_addr     (load_addr),
        .o_load_instr    (load_instr),
        .o_advance       (advance),
        .o_core_reset    (dbg_core_reset),
        .o_reg_addr      (reg_addr)
    );

    pipeline u_pipeline (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_core_reset  (core_reset),
        .i_advance     (advance),
        .i_load_we     (load_we),
        .i_load_addr   (load_addr),
        .i_load_instr  (load_instr),
        .i_reg_addr    (reg_addr),
        .o_reg_data    (reg_data),
        .o_program_end (program_end)
    );

endmodule

/* verilog/uart_receiver.sv */
`timescale 1ns/100ps

module uart_receiver (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_rx,              // Serial line, idle high
    input  logic                            i_baud_tick,       // 16 per bit
    output logic                            o_rx_done,         // One-cycle strobe per frame
    output logic [debug_pkg::WORD_BITS-1:0] o_data
);

    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

    rx_state_e                          state;
    logic [debug_pkg::TICK_BITS-1:0]    tick_cnt;              // Ticks into current bit
    logic [debug_pkg::BIT_CNT_BITS-1:0] bit_cnt;               // Data bits taken
    logic [debug_pkg::WORD_BITS-1:0]    shift_reg;
    logic                               sample;                // Mid-bit point of a data bit

    assign sample = (state == RX_DATA) && i_baud_tick &&
                    (tick_cnt == debug_pkg::STOP_TICKS - 1);
    assign o_data = shift_reg;

    always_ff @(posedge i_clk) begin
        o_rx_done <= 1'b0;
        if (i_reset) begin
            state    <= RX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            case (state)
                RX_IDLE: begin
                    tick_cnt <= '0;
                    if (!i_rx) state <= RX_START;              // Falling edge of start bit
                end
                RX_START: if (i_baud_tick) begin
                    if (tick_cnt == debug_pkg::STOP_TICKS / 2 - 1) begin
                        tick_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= i_rx ? RX_IDLE : RX_DATA;  // Drop glitches
                    end else begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                RX_DATA: if (i_baud_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;               // Wraps every 16 ticks
                    if (sample) begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == debug_pkg::WORD_BITS - 1) state <= RX_STOP;
                    end
                end
                RX_STOP: if (i_baud_tick) begin
                    tick_cnt <= tick_cnt + 1'b1;
                    if (tick_cnt == debug_pkg::STOP_TICKS - 1) begin
                        state     <= RX_IDLE;                  // Middle of stop bit
                        o_rx_done <= 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (sample) shift_reg <= {i_rx, shift_reg[debug_pkg::WORD_BITS-1:1]}; // LSB first
    end

endmodule

/* verilog/uart_transmitter.sv */
`timescale 1ns/100ps

module uart_transmitter (
    input  logic                            i_clk,
    input  logic                            i_reset,
    input  logic                            i_tx_valid,        // FIFO holds a word
    input  logic [debug_pkg::WORD_BITS-1:0] i_data,
    input  logic                            i_baud_tick,
    output logic                            o_tx_done,         // Word taken, pops the FIFO
    output logic                            o_tx
);

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

    tx_state_e                          state;
    logic [debug_pkg::TICK_BITS-1:0]    tick_cnt;
    logic [debug_pkg::BIT_CNT_BITS-1:0] bit_cnt;
    logic [debug_pkg::WORD_BITS-1:0]    shift_reg;
    logic                               bit_end;               // Last tick of current bit

    assign bit_end   = i_baud_tick && (tick_cnt == debug_pkg::STOP_TICKS - 1);
    assign o_tx_done = (state == TX_IDLE) && i_tx_valid;
    assign o_tx      = (state == TX_START) ? 1'b0 :
                       (state == TX_DATA)  ? shift_reg[0] : 1'b1;  // Idle and stop are high

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (state != TX_IDLE && i_baud_tick) tick_cnt <= tick_cnt + 1'b1;
            case (state)
                TX_IDLE: begin
                    tick_cnt <= '0;
                    if (i_tx_valid) state <= TX_START;
                end
                TX_START: if (bit_end) begin
                    bit_cnt <= '0;
                    state   <= TX_DATA;
                end
                TX_DATA: if (bit_end) begin
                    bit_cnt <= bit_cnt + 1'b1;
                    if (bit_cnt == debug_pkg::WORD_BITS - 1) state <= TX_STOP;
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_tx_done) begin
            shift_reg <= i_data;
        end else if (state == TX_DATA && bit_end) begin
            shift_reg <= shift_reg >> 1;                       // Next bit to the line
        end
    end

endmodule
